/* bench/ni_send_props.sv */
`timescale 1ns/100ps
`default_nettype none

module ni_send_props (
    input logic                             clk,
    input logic                             reset,
    input logic                             desc_req_i,
    input logic                             desc_ack_o,
    input logic [ni_send_pkg::CREDIT_W-1:0] count_i,
    input logic                             flit_wr_o
);

    // ack answers a sampled request
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(desc_ack_o) |-> $past(desc_req_i)
    ) else $error("desc_ack_o rose without desc_req_i");

    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        int'(count_i) <= ni_send_pkg::BUF_DEPTH
    ) else $error("credit count above router buffer depth");

    // count excludes the write in progress
    no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        flit_wr_o |-> int'(count_i) < ni_send_pkg::BUF_DEPTH
    ) else $error("flit written with router buffer full");

endmodule

bind ni_send_top ni_send_props ni_send_props_inst (
    .clk        (clk),
    .reset      (reset),
    .desc_req_i (desc_req_i),
    .desc_ack_o (desc_ack_o),
    .count_i    (credit_output_inst.count_q),
    .flit_wr_o  (flit_wr_o)
);

`default_nettype wire

/* bench/ni_send_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ni_send_tb;

    localparam int NUM_DESC   = 5;
    localparam int RESET_CYC  = 16;
    localparam int WORD_BOUND = 40;   // memory wait plus credit stall per word
    localparam int PKT_BOUND  = 60;   // handshake, header and tail per packet
    localparam logic [ni_send_pkg::EADDR_W-1:0] NODE_ADDR = 8'h3c;

    typedef struct packed {
        logic [ni_send_pkg::EADDR_W-1:0] dest;
        logic [ni_send_pkg::CLASS_W-1:0] cls;
        logic [ni_send_pkg::LEN_W-1:0]   len;
        logic [ni_send_pkg::ADDR_W-1:0]  start;
        logic [ni_send_pkg::DATA_W-1:0]  hdr;   // expected header payload with src = NODE_ADDR
    } desc_row_t;

    // dest, class, length, start, expected header payload
    localparam desc_row_t DESC_TAB [NUM_DESC] = '{
        '{8'h12, 2'd1, 10'd1,  16'h0100, 32'h0005_3c12},   // single word
        '{8'h7a, 2'd3, 10'd9,  16'h0200, 32'h0027_3c7a},
        '{8'h05, 2'd0, 10'd3,  16'hfffe, 32'h000c_3c05},   // address wraps
        '{8'hc3, 2'd2, 10'd24, 16'h1230, 32'h0062_3cc3},   // longest
        '{8'h40, 2'd1, 10'd2,  16'h0040, 32'h0009_3c40}
    };

    logic                             clk;
    logic                             reset;
    logic [ni_send_pkg::EADDR_W-1:0]  node_addr_i;
    logic                             desc_req_i;
    logic [ni_send_pkg::EADDR_W-1:0]  desc_dest_i;
    logic [ni_send_pkg::CLASS_W-1:0]  desc_class_i;
    logic [ni_send_pkg::LEN_W-1:0]    desc_len_i;
    logic [ni_send_pkg::ADDR_W-1:0]   desc_addr_i;
    logic                             desc_ack_o;
    logic [ni_send_pkg::ADDR_W-1:0]   mem_addr_o;
    logic                             mem_stb_o;
    logic [ni_send_pkg::DATA_W-1:0]   mem_data_i = '0;
    logic                             mem_ack_i = 1'b0;
    logic [ni_send_pkg::FLIT_W-1:0]   flit_o;
    logic                             flit_wr_o;
    logic                             credit_i = 1'b0;

    ni_send_pkg::flit_t exp_q [$];          // every flit of the run in order
    int unsigned        credit_due_q [$];   // cycle at which each credit comes back
    int unsigned        cycle_cnt = 0;
    int unsigned        limit;
    int                 mem_wait = 0;
    int                 flits_seen = 0;
    int                 outstanding = 0;    // router buffer slots in use
    int                 ack_errors = 0;
    int                 flit_errors = 0;
    int                 protocol_errors = 0;

    ni_send_top ni_send_top_inst (
        .clk          (clk),
        .reset        (reset),
        .node_addr_i  (node_addr_i),
        .desc_req_i   (desc_req_i),
        .desc_dest_i  (desc_dest_i),
        .desc_class_i (desc_class_i),
        .desc_len_i   (desc_len_i),
        .desc_addr_i  (desc_addr_i),
        .desc_ack_o   (desc_ack_o),
        .mem_addr_o   (mem_addr_o),
        .mem_stb_o    (mem_stb_o),
        .mem_data_i   (mem_data_i),
        .mem_ack_i    (mem_ack_i),
        .flit_o       (flit_o),
        .flit_wr_o    (flit_wr_o),
        .credit_i     (credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [ni_send_pkg::DATA_W-1:0] mem_word(
        input logic [ni_send_pkg::ADDR_W-1:0] a);
        return {a ^ 16'h5ac3, ~a} ^ (32'h9e37_79b9 * {16'h0000, a});
    endfunction

    // polynomial 04C11DB7 with the word taken msb first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [31:0] word);
        logic [31:0] c;
        c = crc;
        for (int b = 31; b >= 0; b--) begin
            if (c[31] ^ word[b]) begin
                c = (c << 1) ^ 32'h04c1_1db7;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    function automatic int total_words();
        int n;
        n = 0;
        for (int i = 0; i < NUM_DESC; i++) begin
            n = n + int'(DESC_TAB[i].len);
        end
        return n;
    endfunction

    function automatic void push_packet(input desc_row_t r);
        ni_send_pkg::flit_t             f;
        logic [31:0]                    crc;
        logic [ni_send_pkg::ADDR_W-1:0] a;
        f.flag    = ni_send_pkg::HDR_FLAG;
        f.payload = r.hdr;
        exp_q.push_back(f);
        crc = 32'hffff_ffff;
        a   = r.start;
        for (int k = 0; k < int'(r.len); k++) begin
            f.flag    = ni_send_pkg::BODY_FLAG;
            f.payload = mem_word(a);
            exp_q.push_back(f);
            crc = crc_update(crc, f.payload);
            a   = a + 16'd1;
        end
        f.flag    = ni_send_pkg::TAIL_FLAG;
        f.payload = crc;   // no final xor
        exp_q.push_back(f);
    endfunction

    task automatic check_flit(input ni_send_pkg::flit_t got, input ni_send_pkg::flit_t exp,
                              input string name);
        if (got !== exp) begin
            flit_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            ack_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d ack errors, %0d flit errors, %0d protocol errors, %0d of %0d flits",
                 ack_errors, flit_errors, protocol_errors, flits_seen, exp_q.size());
    endtask

    // fields stay put while req is high
    task automatic send_desc(input desc_row_t r);
        @(negedge clk);
        check_ack(desc_ack_o, 1'b0, "desc_ack_o before req");
        desc_dest_i  = r.dest;
        desc_class_i = r.cls;
        desc_len_i   = r.len;
        desc_addr_i  = r.start;
        desc_req_i   = 1'b1;
        @(negedge clk);
        while (!desc_ack_o) begin
            @(negedge clk);   // hold register still full
        end
        @(negedge clk);
        check_ack(desc_ack_o, 1'b1, "desc_ack_o while req high");
        desc_req_i = 1'b0;
        @(negedge clk);
        check_ack(desc_ack_o, 1'b0, "desc_ack_o after req low");
    endtask

    // memory slave with 0 to 3 wait cycles per strobe
    always @(negedge clk) begin
        if (mem_ack_i) begin
            mem_ack_i = 1'b0;
            if (mem_stb_o) begin
                protocol_errors++;
                $display("mem_stb_o still high at %0t in the cycle after mem_ack_i", $time);
            end
        end else if (mem_stb_o) begin
            if (mem_wait == 0) begin
                mem_data_i = mem_word(mem_addr_o);
                mem_ack_i  = 1'b1;
                mem_wait   = $urandom_range(3, 0);
            end else begin
                mem_wait--;
            end
        end
    end

    // router buffer model and flit checks
    always @(negedge clk) begin
        credit_i = 1'b0;
        if (flit_wr_o) begin
            outstanding++;
            if (outstanding > ni_send_pkg::BUF_DEPTH) begin
                protocol_errors++;
                $display("router buffer overflow at %0t: %0d flits outstanding",
                         $time, outstanding);
            end
            credit_due_q.push_back(cycle_cnt + $urandom_range(6, 1));
            if (flits_seen >= exp_q.size()) begin
                protocol_errors++;
                $display("flit %h written at %0t when no flit was expected", flit_o, $time);
            end else begin
                check_flit(flit_o, exp_q[flits_seen], $sformatf("flit_o #%0d", flits_seen));
            end
            flits_seen++;
        end
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle_cnt) begin
            void'(credit_due_q.pop_front());
            credit_i = 1'b1;
            outstanding--;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout after %0d cycles, packets did not complete", cycle_cnt);
            print_summary();
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h89a));
        reset        = 1'b1;
        node_addr_i  = NODE_ADDR;
        desc_req_i   = 1'b0;
        desc_dest_i  = '0;
        desc_class_i = '0;
        desc_len_i   = '0;
        desc_addr_i  = '0;
        limit = RESET_CYC + WORD_BOUND * total_words() + PKT_BOUND * NUM_DESC;
        for (int i = 0; i < NUM_DESC; i++) begin
            push_packet(DESC_TAB[i]);
        end
        repeat (RESET_CYC) @(posedge clk);
        check_ack(desc_ack_o, 1'b0, "desc_ack_o in reset");
        @(negedge clk);
        reset = 1'b0;
        // later descriptors queue behind earlier ones without waiting for packets
        for (int i = 0; i < NUM_DESC; i++) begin
            send_desc(DESC_TAB[i]);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        while (flits_seen < exp_q.size()) begin
            @(negedge clk);
        end
        while (outstanding != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        print_summary();
        if (ack_errors + flit_errors + protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/ni_send_pkg.sv
hdl/stream_if.sv
hdl/send_descriptor_port.sv
hdl/word_fetch.sv
hdl/flit_framer.sv
hdl/credit_output.sv
hdl/ni_send_top.sv
bench/ni_send_props.sv
bench/ni_send_tb.sv

/* hdl/credit_output.sv */
`timescale 1ns/100ps
`default_nettype none

module credit_output (
    input  logic                            clk,
    input  logic                            reset,
    stream_if.sink                          flit_i,
    input  logic                            credit_i,
    output logic [ni_send_pkg::FLIT_W-1:0]  flit_o,
    output logic                            flit_wr_o
);

    logic [ni_send_pkg::CREDIT_W-1:0]  count_q;   // flits held in the router buffer
    logic [ni_send_pkg::CREDIT_W:0]    pending;
    logic                              wr_q;
    ni_send_pkg::flit_t                flit_q;
    logic                              fire;

    // include the write already on its way out
    assign pending     = {1'b0, count_q} + {{ni_send_pkg::CREDIT_W{1'b0}}, wr_q};
    assign flit_i.ready = pending < ni_send_pkg::BUF_DEPTH;
    assign fire        = flit_i.valid && flit_i.ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
            wr_q    <= 1'b0;
        end else begin
            wr_q <= fire;
            if (wr_q && !credit_i) begin
                count_q <= count_q + 1'b1;
            end else if (!wr_q && credit_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            flit_q <= flit_i.data;
        end
    end

    assign flit_o    = flit_q;
    assign flit_wr_o = wr_q;

endmodule

`default_nettype wire

/* hdl/flit_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module flit_framer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ni_send_pkg::EADDR_W-1:0]  node_addr_i,
    stream_if.sink                           item_i,
    stream_if.source                         flit_o
);

    logic                             flit_valid_q;
    ni_send_pkg::flit_t               flit_q;
    logic                             tail_pend_q;   // last body in the output register
    logic [31:0]                      crc_q;
    logic [ni_send_pkg::DATA_W-1:0]   hdr_payload;
    logic                             item_fire;
    logic                             flit_fire;
    logic                             tail_load;

    assign flit_fire    = flit_valid_q && flit_o.ready;
    assign item_i.ready = !tail_pend_q && (!flit_valid_q || flit_o.ready);
    assign item_fire    = item_i.valid && item_i.ready;
    assign tail_load    = tail_pend_q && flit_fire;

    // desc item already carries dest, class and length
    always_comb begin
        hdr_payload = item_i.data.data;
        hdr_payload[2*ni_send_pkg::EADDR_W-1:ni_send_pkg::EADDR_W] = node_addr_i;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_q <= 1'b0;
            tail_pend_q  <= 1'b0;
        end else begin
            if (item_fire) begin
                flit_valid_q <= 1'b1;
                if (item_i.data.kind == ni_send_pkg::ITEM_LAST) begin
                    tail_pend_q <= 1'b1;
                end
            end else if (tail_load) begin
                flit_valid_q <= 1'b1;   // tail follows right behind
                tail_pend_q  <= 1'b0;
            end else if (flit_fire) begin
                flit_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (item_fire) begin
            if (item_i.data.kind == ni_send_pkg::ITEM_DESC) begin
                flit_q.flag    <= ni_send_pkg::HDR_FLAG;
                flit_q.payload <= hdr_payload;
                crc_q          <= ni_send_pkg::CRC_INIT;   // new packet
            end else begin
                flit_q.flag    <= ni_send_pkg::BODY_FLAG;
                flit_q.payload <= item_i.data.data;
                crc_q          <= ni_send_pkg::crc32_next(crc_q, item_i.data.data);
            end
        end else if (tail_load) begin
            flit_q.flag    <= ni_send_pkg::TAIL_FLAG;
            flit_q.payload <= crc_q;
        end
    end

    assign flit_o.valid = flit_valid_q;
    assign flit_o.data  = flit_q;

endmodule

`default_nettype wire

/* hdl/ni_send_pkg.sv */
`default_nettype none

package ni_send_pkg;

    localparam int DATA_W    = 32;   // memory word and flit payload
    localparam int ADDR_W    = 16;   // word address
    localparam int EADDR_W   = 8;    // endpoint address
    localparam int CLASS_W   = 2;
    localparam int LEN_W     = 10;   // 1 to 1023 words
    localparam int BUF_DEPTH = 4;    // router input buffer, in flits
    localparam int CREDIT_W  = $clog2(BUF_DEPTH + 1);
    localparam int FLIT_W    = 2 + DATA_W;

    // top two flit bits
    localparam logic [1:0] HDR_FLAG  = 2'b10;
    localparam logic [1:0] BODY_FLAG = 2'b00;
    localparam logic [1:0] TAIL_FLAG = 2'b01;

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    typedef struct packed {
        logic [EADDR_W-1:0] dest;
        logic [CLASS_W-1:0] pck_class;
        logic [LEN_W-1:0]   length;
        logic [ADDR_W-1:0]  start;
    } send_desc_t;

    typedef enum logic [1:0] {ITEM_DESC, ITEM_DATA, ITEM_LAST} item_kind_t;

    typedef struct packed {
        item_kind_t        kind;
        logic [DATA_W-1:0] data;   // header layout for desc items, src left zero
    } fetch_item_t;

    typedef struct packed {
        logic [1:0]        flag;
        logic [DATA_W-1:0] payload;
    } flit_t;

    // one word, msb first, no reflection
    function automatic logic [31:0] crc32_next(input logic [31:0] crc,
                                               input logic [DATA_W-1:0] word);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            fb = c[31] ^ word[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* hdl/ni_send_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ni_send_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ni_send_pkg::EADDR_W-1:0]  node_addr_i,
    // descriptor entry, four-phase
    input  logic                             desc_req_i,
    input  logic [ni_send_pkg::EADDR_W-1:0]  desc_dest_i,
    input  logic [ni_send_pkg::CLASS_W-1:0]  desc_class_i,
    input  logic [ni_send_pkg::LEN_W-1:0]    desc_len_i,
    input  logic [ni_send_pkg::ADDR_W-1:0]   desc_addr_i,
    output logic                             desc_ack_o,
    // memory read master
    output logic [ni_send_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic                             mem_stb_o,
    input  logic [ni_send_pkg::DATA_W-1:0]   mem_data_i,
    input  logic                             mem_ack_i,
    // router side
    output logic [ni_send_pkg::FLIT_W-1:0]   flit_o,
    output logic                             flit_wr_o,
    input  logic                             credit_i
);

    stream_if #(.payload_t(ni_send_pkg::send_desc_t))  desc_s ();
    stream_if #(.payload_t(ni_send_pkg::fetch_item_t)) item_s ();
    stream_if #(.payload_t(ni_send_pkg::flit_t))       flit_s ();

    send_descriptor_port send_descriptor_port_inst (
        .clk          (clk),
        .reset        (reset),
        .desc_req_i   (desc_req_i),
        .desc_dest_i  (desc_dest_i),
        .desc_class_i (desc_class_i),
        .desc_len_i   (desc_len_i),
        .desc_addr_i  (desc_addr_i),
        .desc_ack_o   (desc_ack_o),
        .desc_o       (desc_s.source)
    );

    word_fetch word_fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .desc_i     (desc_s.sink),
        .item_o     (item_s.source),
        .mem_addr_o (mem_addr_o),
        .mem_stb_o  (mem_stb_o),
        .mem_data_i (mem_data_i),
        .mem_ack_i  (mem_ack_i)
    );

    flit_framer flit_framer_inst (
        .clk         (clk),
        .reset       (reset),
        .node_addr_i (node_addr_i),
        .item_i      (item_s.sink),
        .flit_o      (flit_s.source)
    );

    credit_output credit_output_inst (
        .clk       (clk),
        .reset     (reset),
        .flit_i    (flit_s.sink),
        .credit_i  (credit_i),
        .flit_o    (flit_o),
        .flit_wr_o (flit_wr_o)
    );

endmodule

`default_nettype wire

/* hdl/send_descriptor_port.sv */
`timescale 1ns/100ps
`default_nettype none

module send_descriptor_port (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             desc_req_i,
    input  logic [ni_send_pkg::EADDR_W-1:0]  desc_dest_i,
    input  logic [ni_send_pkg::CLASS_W-1:0]  desc_class_i,
    input  logic [ni_send_pkg::LEN_W-1:0]    desc_len_i,
    input  logic [ni_send_pkg::ADDR_W-1:0]   desc_addr_i,
    output logic                             desc_ack_o,
    stream_if.source                         desc_o
);

    logic                    ack_q;
    logic                    full_q;   // hold register occupied
    ni_send_pkg::send_desc_t hold_q;
    logic                    take;

    // new request, previous handshake closed, room to store
    assign take = desc_req_i && !ack_q && !full_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q  <= 1'b0;
            full_q <= 1'b0;
        end else begin
            if (take) begin
                ack_q <= 1'b1;
            end else if (!desc_req_i) begin
                ack_q <= 1'b0;   // phase 4, follows req down
            end

            if (take) begin
                full_q <= 1'b1;
            end else if (desc_o.valid && desc_o.ready) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_q.dest      <= desc_dest_i;
            hold_q.pck_class <= desc_class_i;
            hold_q.length    <= desc_len_i;
            hold_q.start     <= desc_addr_i;
        end
    end

    assign desc_ack_o   = ack_q;
    assign desc_o.valid = full_q;
    assign desc_o.data  = hold_q;

endmodule

`default_nettype wire

/* hdl/stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

// valid/ready stream, one item per cycle when both are high
interface stream_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/word_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module word_fetch (
    input  logic                            clk,
    input  logic                            reset,
    stream_if.sink                          desc_i,
    stream_if.source                        item_o,
    output logic [ni_send_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic                            mem_stb_o,
    input  logic [ni_send_pkg::DATA_W-1:0]  mem_data_i,
    input  logic                            mem_ack_i
);

    typedef enum logic {S_IDLE, S_READ} state_t;

    state_t                            state_q;
    logic [ni_send_pkg::ADDR_W-1:0]    addr_q;
    logic [ni_send_pkg::LEN_W-1:0]     left_q;   // words still to read
    logic                              stb_q;
    logic                              item_valid_q;
    ni_send_pkg::fetch_item_t          item_q;
    logic                              out_free;
    logic                              desc_fire;
    logic                              mem_done;

    assign out_free     = !item_valid_q || item_o.ready;   // empty or leaving now
    assign desc_i.ready = (state_q == S_IDLE) && out_free;
    assign desc_fire    = desc_i.valid && desc_i.ready;
    assign mem_done     = stb_q && mem_ack_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q      <= S_IDLE;
            addr_q       <= '0;
            left_q       <= '0;
            stb_q        <= 1'b0;
            item_valid_q <= 1'b0;
        end else begin
            if (item_valid_q && item_o.ready) begin
                item_valid_q <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (desc_fire) begin
                        item_valid_q <= 1'b1;   // header item first
                        addr_q       <= desc_i.data.start;
                        left_q       <= desc_i.data.length;
                        state_q      <= S_READ;
                    end
                end
                S_READ: begin
                    if (mem_done) begin
                        stb_q        <= 1'b0;   // at least one idle cycle between strobes
                        item_valid_q <= 1'b1;
                        addr_q       <= addr_q + 1'b1;
                        left_q       <= left_q - 1'b1;
                        if (left_q == 1) begin
                            state_q <= S_IDLE;
                        end
                    end else if (!stb_q && out_free) begin
                        stb_q <= 1'b1;   // stall while the previous item waits
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (desc_fire) begin
            item_q.kind <= ni_send_pkg::ITEM_DESC;
            item_q.data <= {{(ni_send_pkg::DATA_W - 2 * ni_send_pkg::EADDR_W
                              - ni_send_pkg::CLASS_W - ni_send_pkg::LEN_W){1'b0}},
                            desc_i.data.length,
                            desc_i.data.pck_class,
                            {ni_send_pkg::EADDR_W{1'b0}},   // src slot, framer fills it
                            desc_i.data.dest};
        end else if (mem_done) begin
            item_q.kind <= (left_q == 1) ? ni_send_pkg::ITEM_LAST : ni_send_pkg::ITEM_DATA;
            item_q.data <= mem_data_i;
        end
    end

    assign item_o.valid = item_valid_q;
    assign item_o.data  = item_q;
    assign mem_addr_o   = addr_q;
    assign mem_stb_o    = stb_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the send path testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module ni_send_tb -o ni_send_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ni_send_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
